// ==== riscv_lite.f ====
+incdir+tb
src/rv_pkg.sv
src/fetch_unit.sv
src/reg_file.sv
src/decode_stage.sv
src/execute_stage.sv
src/result_stage.sv
src/cpu_core.sv
tb/cpu_core_tb.sv

// ==== src/cpu_core.sv ====
`timescale 1ns/1ps

module cpu_core (
  input  logic                         clk,
  input  logic                         rst,
  output logic                         im_en_o,
  output logic [rv_pkg::IM_ADDR_W-1:0] im_addr_o,
  input  logic [rv_pkg::XLEN-1:0]      im_data_i,
  output logic [rv_pkg::DM_ADDR_W-1:0] dm_addr_o,
  output logic [rv_pkg::XLEN-1:0]      dm_di_o,
  output logic [3:0]                   dm_web_o
);
  import rv_pkg::*;

  logic                  fetch_valid;
  logic [REG_ADDR_W-1:0] rs1_idx;
  logic [REG_ADDR_W-1:0] rs2_idx;
  logic [XLEN-1:0]       rs1_rdata;
  logic [XLEN-1:0]       rs2_rdata;

  // ID/EX
  logic [ALU_SEL_W-1:0]  ex_alu_sel;
  logic                  ex_use_imm;
  logic                  ex_reg_write;
  logic                  ex_store;
  logic [REG_ADDR_W-1:0] ex_rd;
  logic [REG_ADDR_W-1:0] ex_rs1;
  logic [REG_ADDR_W-1:0] ex_rs2;
  logic [XLEN-1:0]       ex_rs1_data;
  logic [XLEN-1:0]       ex_rs2_data;
  logic [XLEN-1:0]       ex_imm;

  // EX to EX/ME
  logic [XLEN-1:0]       alu_result;
  logic                  reg_write;
  logic [REG_ADDR_W-1:0] rd;

  // ME and WB
  logic                  me_reg_write;
  logic [REG_ADDR_W-1:0] me_rd;
  logic [XLEN-1:0]       me_result;
  logic                  wb_reg_write;
  logic [REG_ADDR_W-1:0] wb_rd;
  logic [XLEN-1:0]       wb_data;

  fetch_unit u_fetch (
    .clk           (clk),
    .rst           (rst),
    .im_en_o       (im_en_o),
    .im_addr_o     (im_addr_o),
    .fetch_valid_o (fetch_valid)
  );

  reg_file u_regs (
    .clk        (clk),
    .rst        (rst),
    .rs1_i      (rs1_idx),
    .rs2_i      (rs2_idx),
    .rs1_data_o (rs1_rdata),
    .rs2_data_o (rs2_rdata),
    .we_i       (wb_reg_write),
    .rd_i       (wb_rd),
    .rd_data_i  (wb_data)
  );

  decode_stage u_decode (
    .clk            (clk),
    .rst            (rst),
    .fetch_valid_i  (fetch_valid),
    .instr_i        (im_data_i),
    .rs1_data_i     (rs1_rdata),
    .rs2_data_i     (rs2_rdata),
    .rs1_o          (rs1_idx),
    .rs2_o          (rs2_idx),
    .ex_alu_sel_o   (ex_alu_sel),
    .ex_use_imm_o   (ex_use_imm),
    .ex_reg_write_o (ex_reg_write),
    .ex_store_o     (ex_store),
    .ex_rd_o        (ex_rd),
    .ex_rs1_o       (ex_rs1),
    .ex_rs2_o       (ex_rs2),
    .ex_rs1_data_o  (ex_rs1_data),
    .ex_rs2_data_o  (ex_rs2_data),
    .ex_imm_o       (ex_imm)
  );

  execute_stage u_execute (
    .ex_alu_sel_i   (ex_alu_sel),
    .ex_use_imm_i   (ex_use_imm),
    .ex_reg_write_i (ex_reg_write),
    .ex_store_i     (ex_store),
    .ex_rd_i        (ex_rd),
    .ex_rs1_i       (ex_rs1),
    .ex_rs2_i       (ex_rs2),
    .ex_rs1_data_i  (ex_rs1_data),
    .ex_rs2_data_i  (ex_rs2_data),
    .ex_imm_i       (ex_imm),
    .me_reg_write_i (me_reg_write),
    .me_rd_i        (me_rd),
    .me_result_i    (me_result),
    .wb_reg_write_i (wb_reg_write),
    .wb_rd_i        (wb_rd),
    .wb_data_i      (wb_data),
    .alu_result_o   (alu_result),
    .reg_write_o    (reg_write),
    .rd_o           (rd),
    .dm_addr_o      (dm_addr_o),
    .dm_di_o        (dm_di_o),
    .dm_web_o       (dm_web_o)
  );

  result_stage u_result (
    .clk            (clk),
    .rst            (rst),
    .alu_result_i   (alu_result),
    .reg_write_i    (reg_write),
    .rd_i           (rd),
    .me_reg_write_o (me_reg_write),
    .me_rd_o        (me_rd),
    .me_result_o    (me_result),
    .wb_reg_write_o (wb_reg_write),
    .wb_rd_o        (wb_rd),
    .wb_data_o      (wb_data)
  );

endmodule

// ==== src/decode_stage.sv ====
`timescale 1ns/1ps

module decode_stage (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          fetch_valid_i,
  input  logic [rv_pkg::XLEN-1:0]       instr_i,
  input  logic [rv_pkg::XLEN-1:0]       rs1_data_i,
  input  logic [rv_pkg::XLEN-1:0]       rs2_data_i,
  output logic [rv_pkg::REG_ADDR_W-1:0] rs1_o,
  output logic [rv_pkg::REG_ADDR_W-1:0] rs2_o,
  output logic [rv_pkg::ALU_SEL_W-1:0]  ex_alu_sel_o,
  output logic                          ex_use_imm_o,
  output logic                          ex_reg_write_o,
  output logic                          ex_store_o,
  output logic [rv_pkg::REG_ADDR_W-1:0] ex_rd_o,
  output logic [rv_pkg::REG_ADDR_W-1:0] ex_rs1_o,
  output logic [rv_pkg::REG_ADDR_W-1:0] ex_rs2_o,
  output logic [rv_pkg::XLEN-1:0]       ex_rs1_data_o,
  output logic [rv_pkg::XLEN-1:0]       ex_rs2_data_o,
  output logic [rv_pkg::XLEN-1:0]       ex_imm_o
);
  import rv_pkg::*;

  instr_u               ins;
  logic [ALU_SEL_W-1:0] alu_sel;
  logic                 use_imm;
  logic                 reg_write;
  logic                 store;
  logic [XLEN-1:0]      imm;

  // funct7 bit 5 picks SUB only for register ops, SRA for both
  function automatic logic [ALU_SEL_W-1:0] alu_sel_f(input logic [2:0] funct3,
                                                     input logic       alt,
                                                     input logic       reg_op);
    case (funct3)
      3'b000:  return (alt && reg_op) ? ALU_SUB : ALU_ADD;
      3'b001:  return ALU_SLL;
      3'b010:  return ALU_SLT;
      3'b011:  return ALU_SLTU;
      3'b100:  return ALU_XOR;
      3'b101:  return alt ? ALU_SRA : ALU_SRL;
      3'b110:  return ALU_OR;
      default: return ALU_AND;
    endcase
  endfunction

  assign ins = instr_i;

  // ---------------------------------------------------------------------
  // Decode and immediate generation
  // ---------------------------------------------------------------------
  always_comb begin
    alu_sel   = ALU_ADD;
    use_imm   = 1'b0;
    reg_write = 1'b0;
    store     = 1'b0;
    imm       = '0;
    rs1_o     = ins.r.rs1;
    rs2_o     = ins.r.rs2;
    case (ins.r.opcode)
      OP_RTYPE: begin
        alu_sel   = alu_sel_f(ins.r.funct3, ins.r.funct7[5], 1'b1);
        reg_write = 1'b1;
      end
      OP_ITYPE: begin
        alu_sel   = alu_sel_f(ins.i.funct3, ins.r.funct7[5], 1'b0);
        use_imm   = 1'b1;
        reg_write = 1'b1;
        imm       = {{(XLEN-12){ins.i.imm12[11]}}, ins.i.imm12};
      end
      OP_LUI: begin
        // x0 + upper immediate
        alu_sel   = ALU_PASS_B;
        use_imm   = 1'b1;
        reg_write = 1'b1;
        rs1_o     = '0;
        imm       = {instr_i[XLEN-1:12], 12'b0};
      end
      OP_STORE: begin
        // Word stores only
        if (ins.s.funct3 == 3'b010) begin
          use_imm = 1'b1;
          store   = 1'b1;
          imm     = {{(XLEN-12){ins.s.imm_hi[6]}}, ins.s.imm_hi, ins.s.imm_lo};
        end
      end
      default: begin
      end
    endcase
    if (!fetch_valid_i) begin
      reg_write = 1'b0;
      store     = 1'b0;
    end
  end

  // ---------------------------------------------------------------------
  // ID/EX register
  // ---------------------------------------------------------------------
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      ex_alu_sel_o   <= ALU_ADD;
      ex_use_imm_o   <= 1'b0;
      ex_reg_write_o <= 1'b0;
      ex_store_o     <= 1'b0;
      ex_rd_o        <= '0;
      ex_rs1_o       <= '0;
      ex_rs2_o       <= '0;
    end else begin
      ex_alu_sel_o   <= alu_sel;
      ex_use_imm_o   <= use_imm;
      ex_reg_write_o <= reg_write;
      ex_store_o     <= store;
      ex_rd_o        <= ins.r.rd;
      ex_rs1_o       <= rs1_o;
      ex_rs2_o       <= rs2_o;
    end
  end

  always_ff @(posedge clk) begin
    ex_rs1_data_o <= rs1_data_i;
    ex_rs2_data_o <= rs2_data_i;
    ex_imm_o      <= imm;
  end

  a_instr_known: assert property (@(posedge clk) disable iff (rst)
    fetch_valid_i |-> !$isunknown(instr_i))
    else $error("Fetched instruction has X bits: %h", instr_i);

endmodule

// ==== src/execute_stage.sv ====
`timescale 1ns/1ps

module execute_stage (
  input  logic [rv_pkg::ALU_SEL_W-1:0]  ex_alu_sel_i,
  input  logic                          ex_use_imm_i,
  input  logic                          ex_reg_write_i,
  input  logic                          ex_store_i,
  input  logic [rv_pkg::REG_ADDR_W-1:0] ex_rd_i,
  input  logic [rv_pkg::REG_ADDR_W-1:0] ex_rs1_i,
  input  logic [rv_pkg::REG_ADDR_W-1:0] ex_rs2_i,
  input  logic [rv_pkg::XLEN-1:0]       ex_rs1_data_i,
  input  logic [rv_pkg::XLEN-1:0]       ex_rs2_data_i,
  input  logic [rv_pkg::XLEN-1:0]       ex_imm_i,
  input  logic                          me_reg_write_i,
  input  logic [rv_pkg::REG_ADDR_W-1:0] me_rd_i,
  input  logic [rv_pkg::XLEN-1:0]       me_result_i,
  input  logic                          wb_reg_write_i,
  input  logic [rv_pkg::REG_ADDR_W-1:0] wb_rd_i,
  input  logic [rv_pkg::XLEN-1:0]       wb_data_i,
  output logic [rv_pkg::XLEN-1:0]       alu_result_o,
  output logic                          reg_write_o,
  output logic [rv_pkg::REG_ADDR_W-1:0] rd_o,
  output logic [rv_pkg::DM_ADDR_W-1:0]  dm_addr_o,
  output logic [rv_pkg::XLEN-1:0]       dm_di_o,
  output logic [3:0]                    dm_web_o
);
  import rv_pkg::*;

  logic [XLEN-1:0] rs1_fwd;
  logic [XLEN-1:0] rs2_fwd;
  logic [XLEN-1:0] op_b;
  logic [4:0]      shamt;

  // ---------------------------------------------------------------------
  // Forwarding, youngest producer first
  // ---------------------------------------------------------------------
  function automatic logic [XLEN-1:0] forward(input logic [REG_ADDR_W-1:0] idx,
                                              input logic [XLEN-1:0]       reg_val);
    if (me_reg_write_i && me_rd_i != '0 && me_rd_i == idx) begin
      return me_result_i;
    end else if (wb_reg_write_i && wb_rd_i != '0 && wb_rd_i == idx) begin
      return wb_data_i;
    end
    return reg_val;
  endfunction

  always_comb begin
    rs1_fwd = forward(ex_rs1_i, ex_rs1_data_i);
    rs2_fwd = forward(ex_rs2_i, ex_rs2_data_i);
  end

  // ---------------------------------------------------------------------
  // ALU
  // ---------------------------------------------------------------------
  assign op_b  = ex_use_imm_i ? ex_imm_i : rs2_fwd;
  assign shamt = op_b[4:0];

  always_comb begin
    case (ex_alu_sel_i)
      ALU_ADD:    alu_result_o = rs1_fwd + op_b;
      ALU_SUB:    alu_result_o = rs1_fwd - op_b;
      ALU_SLL:    alu_result_o = rs1_fwd << shamt;
      ALU_SLT:    alu_result_o = XLEN'($signed(rs1_fwd) < $signed(op_b));
      ALU_SLTU:   alu_result_o = XLEN'(rs1_fwd < op_b);
      ALU_XOR:    alu_result_o = rs1_fwd ^ op_b;
      ALU_SRL:    alu_result_o = rs1_fwd >> shamt;
      ALU_SRA:    alu_result_o = $unsigned($signed(rs1_fwd) >>> shamt);
      ALU_OR:     alu_result_o = rs1_fwd | op_b;
      ALU_AND:    alu_result_o = rs1_fwd & op_b;
      ALU_PASS_B: alu_result_o = op_b;
      default:    alu_result_o = '0;
    endcase
  end

  assign reg_write_o = ex_reg_write_i;
  assign rd_o        = ex_rd_i;

  // Store port, word aligned, data from the forwarded rs2
  assign dm_addr_o = alu_result_o[DM_ADDR_W+1:2];
  assign dm_di_o   = rs2_fwd;
  assign dm_web_o  = ex_store_i ? WEB_WORD : WEB_IDLE;

  // A store never also writes a register
  a_web_legal: assert final (dm_web_o == WEB_IDLE ||
                             (dm_web_o == WEB_WORD && !reg_write_o))
    else $error("Illegal store enable %h with reg_write=%b", dm_web_o, reg_write_o);

endmodule

// ==== src/fetch_unit.sv ====
`timescale 1ns/1ps

module fetch_unit (
  input  logic                         clk,
  input  logic                         rst,
  output logic                         im_en_o,
  output logic [rv_pkg::IM_ADDR_W-1:0] im_addr_o,
  output logic                         fetch_valid_o
);
  import rv_pkg::*;

  logic [XLEN-1:0] pc_q;

  // Enable comes up one cycle after reset, PC steps once enabled
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      im_en_o       <= 1'b0;
      fetch_valid_o <= 1'b0;
      pc_q          <= '0;
    end else begin
      im_en_o       <= 1'b1;
      fetch_valid_o <= im_en_o;
      if (im_en_o) begin
        pc_q <= pc_q + XLEN'(4);
      end
    end
  end

  assign im_addr_o = pc_q[IM_ADDR_W+1:2];

  a_pc_step: assert property (@(posedge clk) disable iff (rst)
    im_en_o |=> pc_q == $past(pc_q) + XLEN'(4))
    else $error("PC did not advance by 4, pc=%h", pc_q);

endmodule

// ==== src/reg_file.sv ====
`timescale 1ns/1ps

module reg_file (
  input  logic                          clk,
  input  logic                          rst,
  input  logic [rv_pkg::REG_ADDR_W-1:0] rs1_i,
  input  logic [rv_pkg::REG_ADDR_W-1:0] rs2_i,
  output logic [rv_pkg::XLEN-1:0]       rs1_data_o,
  output logic [rv_pkg::XLEN-1:0]       rs2_data_o,
  input  logic                          we_i,
  input  logic [rv_pkg::REG_ADDR_W-1:0] rd_i,
  input  logic [rv_pkg::XLEN-1:0]       rd_data_i
);
  import rv_pkg::*;

  // x0 has no storage
  logic [XLEN-1:0] regs [1:31];

  // Same-cycle write wins over the stored value
  function automatic logic [XLEN-1:0] read_port(input logic [REG_ADDR_W-1:0] idx);
    if (idx == '0) begin
      return '0;
    end else if (we_i && rd_i == idx) begin
      return rd_data_i;
    end
    return regs[idx];
  endfunction

  always_comb begin
    rs1_data_o = read_port(rs1_i);
    rs2_data_o = read_port(rs2_i);
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we_i && rd_i != '0) begin
      regs[rd_i] <= rd_data_i;
    end
  end

  a_wdata_known: assert property (@(posedge clk) disable iff (rst)
    we_i |-> !$isunknown(rd_data_i))
    else $error("Write-back data has X bits, rd=%0d", rd_i);

endmodule

// ==== src/result_stage.sv ====
`timescale 1ns/1ps

module result_stage (
  input  logic                          clk,
  input  logic                          rst,
  input  logic [rv_pkg::XLEN-1:0]       alu_result_i,
  input  logic                          reg_write_i,
  input  logic [rv_pkg::REG_ADDR_W-1:0] rd_i,
  output logic                          me_reg_write_o,
  output logic [rv_pkg::REG_ADDR_W-1:0] me_rd_o,
  output logic [rv_pkg::XLEN-1:0]       me_result_o,
  output logic                          wb_reg_write_o,
  output logic [rv_pkg::REG_ADDR_W-1:0] wb_rd_o,
  output logic [rv_pkg::XLEN-1:0]       wb_data_o
);

  // EX/ME and ME/WB controls, writes to x0 dropped here
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      me_reg_write_o <= 1'b0;
      me_rd_o        <= '0;
      wb_reg_write_o <= 1'b0;
      wb_rd_o        <= '0;
    end else begin
      me_reg_write_o <= reg_write_i && (rd_i != '0);
      me_rd_o        <= rd_i;
      wb_reg_write_o <= me_reg_write_o;
      wb_rd_o        <= me_rd_o;
    end
  end

  // Result data, no loads so ME passes the ALU value on
  always_ff @(posedge clk) begin
    me_result_o <= alu_result_i;
    wb_data_o   <= me_result_o;
  end

endmodule

// ==== src/rv_pkg.sv ====
package rv_pkg;

  // ---------------------------------------------------------------------
  // Widths
  // ---------------------------------------------------------------------
  localparam int XLEN       = 32;
  localparam int REG_ADDR_W = 5;

  // Word addresses, taken from byte address bits 15 to 2
  localparam int IM_ADDR_W  = 14;
  localparam int DM_ADDR_W  = 14;

  // ---------------------------------------------------------------------
  // Opcodes
  // ---------------------------------------------------------------------
  localparam logic [6:0] OP_RTYPE = 7'b0110011;
  localparam logic [6:0] OP_ITYPE = 7'b0010011;
  localparam logic [6:0] OP_STORE = 7'b0100011;
  localparam logic [6:0] OP_LUI   = 7'b0110111;

  // ---------------------------------------------------------------------
  // ALU select codes
  // ---------------------------------------------------------------------
  localparam int ALU_SEL_W = 4;

  localparam logic [ALU_SEL_W-1:0] ALU_ADD    = 4'd0;
  localparam logic [ALU_SEL_W-1:0] ALU_SUB    = 4'd1;
  localparam logic [ALU_SEL_W-1:0] ALU_SLL    = 4'd2;
  localparam logic [ALU_SEL_W-1:0] ALU_SLT    = 4'd3;
  localparam logic [ALU_SEL_W-1:0] ALU_SLTU   = 4'd4;
  localparam logic [ALU_SEL_W-1:0] ALU_XOR    = 4'd5;
  localparam logic [ALU_SEL_W-1:0] ALU_SRL    = 4'd6;
  localparam logic [ALU_SEL_W-1:0] ALU_SRA    = 4'd7;
  localparam logic [ALU_SEL_W-1:0] ALU_OR     = 4'd8;
  localparam logic [ALU_SEL_W-1:0] ALU_AND    = 4'd9;
  // Operand B straight through, for LUI
  localparam logic [ALU_SEL_W-1:0] ALU_PASS_B = 4'd10;

  // Data SRAM byte write enables, active low
  localparam logic [3:0] WEB_IDLE = 4'b1111;
  localparam logic [3:0] WEB_WORD = 4'b0000;

  // One fetched word seen as R, I or S format
  typedef union packed {
    struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
    } r;
    struct packed {
      logic [11:0] imm12;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } i;
    struct packed {
      logic [6:0] imm_hi;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] imm_lo;
      logic [6:0] opcode;
    } s;
  } instr_u;

endpackage

// ==== tb/prog_table.svh ====
`ifndef PROG_TABLE_SVH
`define PROG_TABLE_SVH

// ---------------------------------------------------------------------
// RV32I encoding fields
// ---------------------------------------------------------------------
localparam logic [6:0] OPC_REG   = 7'b0110011;
localparam logic [6:0] OPC_IMM   = 7'b0010011;
localparam logic [6:0] OPC_STORE = 7'b0100011;
localparam logic [6:0] OPC_LUI   = 7'b0110111;

localparam logic [2:0] F3_ADD  = 3'd0;
localparam logic [2:0] F3_SLL  = 3'd1;
localparam logic [2:0] F3_SLT  = 3'd2;
localparam logic [2:0] F3_SLTU = 3'd3;
localparam logic [2:0] F3_XOR  = 3'd4;
localparam logic [2:0] F3_SR   = 3'd5;
localparam logic [2:0] F3_OR   = 3'd6;
localparam logic [2:0] F3_AND  = 3'd7;

localparam logic [6:0] F7_BASE = 7'h00;
// SUB and SRA
localparam logic [6:0] F7_ALT  = 7'h20;

// addi x0, x0, 0
localparam logic [31:0] NOP_WORD = 32'h0000_0013;

// Data SRAM byte write enables, active low
localparam logic [3:0] WEB_IDLE = 4'b1111;
localparam logic [3:0] WEB_WORD = 4'b0000;

logic [31:0] prog_q [$];
logic [13:0] exp_addr_q [$];
logic [31:0] exp_data_q [$];

function automatic logic [31:0] reg_op(input logic [6:0] f7, input logic [2:0] f3,
                                       input logic [4:0] rd, input logic [4:0] rs1,
                                       input logic [4:0] rs2);
  return {f7, rs2, rs1, f3, rd, OPC_REG};
endfunction

function automatic logic [31:0] imm_op(input logic [2:0] f3, input logic [4:0] rd,
                                       input logic [4:0] rs1, input logic [11:0] imm);
  return {imm, rs1, f3, rd, OPC_IMM};
endfunction

function automatic logic [31:0] lui_op(input logic [4:0] rd, input logic [19:0] imm);
  return {imm, rd, OPC_LUI};
endfunction

// One SW in the program and the word it must write
task automatic sw_expect(input logic [4:0] rs2, input logic [4:0] rs1,
                         input logic [11:0] imm, input logic [13:0] addr,
                         input logic [31:0] data);
  prog_q.push_back({imm[11:5], rs2, rs1, 3'b010, imm[4:0], OPC_STORE});
  exp_addr_q.push_back(addr);
  exp_data_q.push_back(data);
endtask

task automatic build_tables();
  // LUI and ADDI constants, x1 forwarded at distance 1
  prog_q.push_back(lui_op(5'd1, 20'h12345));
  prog_q.push_back(imm_op(F3_ADD, 5'd1, 5'd1, 12'h678));
  sw_expect(5'd1, 5'd0, 12'h100, 14'h040, 32'h1234_5678);
  // x2 = -5, x3 = 3
  prog_q.push_back(imm_op(F3_ADD, 5'd2, 5'd0, 12'hFFB));
  prog_q.push_back(imm_op(F3_ADD, 5'd3, 5'd0, 12'h003));
  prog_q.push_back(reg_op(F7_BASE, F3_ADD, 5'd4, 5'd2, 5'd3));
  prog_q.push_back(reg_op(F7_ALT, F3_ADD, 5'd5, 5'd2, 5'd3));
  sw_expect(5'd4, 5'd0, 12'h104, 14'h041, 32'hFFFF_FFFE);
  sw_expect(5'd5, 5'd0, 12'h108, 14'h042, 32'hFFFF_FFF8);
  // Arithmetic against logical shift of a negative value
  prog_q.push_back(reg_op(F7_ALT, F3_SR, 5'd6, 5'd2, 5'd3));
  prog_q.push_back(reg_op(F7_BASE, F3_SR, 5'd7, 5'd2, 5'd3));
  sw_expect(5'd6, 5'd0, 12'h10C, 14'h043, 32'hFFFF_FFFF);
  sw_expect(5'd7, 5'd0, 12'h110, 14'h044, 32'h1FFF_FFFF);
  // Signed and unsigned compare with mixed signs
  prog_q.push_back(reg_op(F7_BASE, F3_SLT, 5'd8, 5'd2, 5'd3));
  prog_q.push_back(reg_op(F7_BASE, F3_SLTU, 5'd9, 5'd2, 5'd3));
  sw_expect(5'd8, 5'd0, 12'h114, 14'h045, 32'h0000_0001);
  sw_expect(5'd9, 5'd0, 12'h118, 14'h046, 32'h0000_0000);
  prog_q.push_back(reg_op(F7_BASE, F3_SLL, 5'd10, 5'd1, 5'd3));
  prog_q.push_back(reg_op(F7_BASE, F3_XOR, 5'd11, 5'd1, 5'd2));
  prog_q.push_back(reg_op(F7_BASE, F3_OR, 5'd12, 5'd1, 5'd3));
  prog_q.push_back(reg_op(F7_BASE, F3_AND, 5'd13, 5'd1, 5'd10));
  sw_expect(5'd10, 5'd0, 12'h11C, 14'h047, 32'h91A2_B3C0);
  sw_expect(5'd11, 5'd0, 12'h120, 14'h048, 32'hEDCB_A983);
  sw_expect(5'd12, 5'd0, 12'h124, 14'h049, 32'h1234_567B);
  sw_expect(5'd13, 5'd0, 12'h128, 14'h04A, 32'h1020_1240);
  // Immediate forms
  prog_q.push_back(imm_op(F3_SLT, 5'd14, 5'd2, 12'h005));
  prog_q.push_back(imm_op(F3_SLTU, 5'd15, 5'd2, 12'h005));
  prog_q.push_back(imm_op(F3_XOR, 5'd16, 5'd1, 12'hFFF));
  prog_q.push_back(imm_op(F3_OR, 5'd17, 5'd3, 12'h7F0));
  prog_q.push_back(imm_op(F3_AND, 5'd18, 5'd1, 12'h0FF));
  prog_q.push_back(imm_op(F3_SLL, 5'd19, 5'd3, 12'h01E));
  prog_q.push_back(imm_op(F3_SR, 5'd20, 5'd19, 12'h004));
  prog_q.push_back(imm_op(F3_SR, 5'd21, 5'd19, 12'h404));
  sw_expect(5'd14, 5'd0, 12'h12C, 14'h04B, 32'h0000_0001);
  sw_expect(5'd15, 5'd0, 12'h130, 14'h04C, 32'h0000_0000);
  sw_expect(5'd16, 5'd0, 12'h134, 14'h04D, 32'hEDCB_A987);
  sw_expect(5'd17, 5'd0, 12'h138, 14'h04E, 32'h0000_07F3);
  sw_expect(5'd18, 5'd0, 12'h13C, 14'h04F, 32'h0000_0078);
  sw_expect(5'd19, 5'd0, 12'h140, 14'h050, 32'hC000_0000);
  sw_expect(5'd20, 5'd0, 12'h144, 14'h051, 32'h0C00_0000);
  sw_expect(5'd21, 5'd0, 12'h148, 14'h052, 32'hFC00_0000);
  // Forwarding distances 1, 2 and 3 from x22
  prog_q.push_back(imm_op(F3_ADD, 5'd22, 5'd0, 12'd100));
  prog_q.push_back(imm_op(F3_ADD, 5'd23, 5'd22, 12'd1));
  prog_q.push_back(imm_op(F3_ADD, 5'd24, 5'd22, 12'd2));
  prog_q.push_back(imm_op(F3_ADD, 5'd25, 5'd22, 12'd3));
  prog_q.push_back(reg_op(F7_BASE, F3_ADD, 5'd26, 5'd23, 5'd24));
  sw_expect(5'd26, 5'd0, 12'h14C, 14'h053, 32'd203);
  sw_expect(5'd25, 5'd0, 12'h150, 14'h054, 32'd103);
  // Base register other than x0
  sw_expect(5'd24, 5'd22, 12'h0F0, 14'h055, 32'd102);
  // Writes to x0 must vanish
  prog_q.push_back(imm_op(F3_ADD, 5'd0, 5'd0, 12'd77));
  prog_q.push_back(reg_op(F7_BASE, F3_ADD, 5'd27, 5'd0, 5'd0));
  sw_expect(5'd27, 5'd0, 12'h158, 14'h056, 32'h0000_0000);
  prog_q.push_back(lui_op(5'd0, 20'hABCDE));
  sw_expect(5'd0, 5'd0, 12'h15C, 14'h057, 32'h0000_0000);
  prog_q.push_back(imm_op(F3_ADD, 5'd28, 5'd0, 12'h055));
  sw_expect(5'd28, 5'd0, 12'h160, 14'h058, 32'h0000_0055);
  // Negative low part under LUI
  prog_q.push_back(lui_op(5'd29, 20'h87654));
  prog_q.push_back(imm_op(F3_ADD, 5'd29, 5'd29, 12'hCDE));
  sw_expect(5'd29, 5'd0, 12'h164, 14'h059, 32'h8765_3CDE);
endtask

`endif

// ==== tb/cpu_core_tb.sv ====
`timescale 1ns/1ps

module cpu_core_tb;

  `include "prog_table.svh"

  localparam int IMEM_DEPTH    = 64;
  localparam int RESET_CYCLES  = 8;
  localparam int PIPE_CYCLES   = 8;
  localparam int MARGIN_CYCLES = 20;

  logic        clk;
  logic        rst;
  logic        im_en;
  logic [13:0] im_addr;
  logic [31:0] im_data;
  logic [13:0] dm_addr;
  logic [31:0] dm_di;
  logic [3:0]  dm_web;

  logic [31:0] imem [0:IMEM_DEPTH-1];
  int          err_cnt;
  int          store_cnt;
  int          rst_cycle_cnt;
  // Rising edges since reset release
  int          cycle_cnt;
  int          run_limit;

  cpu_core dut0 (
    .clk       (clk),
    .rst       (rst),
    .im_en_o   (im_en),
    .im_addr_o (im_addr),
    .im_data_i (im_data),
    .dm_addr_o (dm_addr),
    .dm_di_o   (dm_di),
    .dm_web_o  (dm_web)
  );

  always #5 clk = ~clk;

  // ---------------------------------------------------------------------
  // Instruction SRAM model
  // ---------------------------------------------------------------------
  function automatic logic [31:0] imem_read(input logic [13:0] addr);
    if (addr < IMEM_DEPTH) begin
      return imem[addr];
    end
    return NOP_WORD;
  endfunction

  task automatic load_imem();
    for (int i = 0; i < IMEM_DEPTH; i++) begin
      if (i < prog_q.size()) begin
        imem[i] = prog_q[i];
      end else begin
        imem[i] = NOP_WORD;
      end
    end
  endtask

  // Word for the address seen at this edge, driven 1 ns later
  always @(posedge clk) begin
    logic [31:0] word;
    word = imem_read(im_addr);
    if (im_en) begin
      #1;
      im_data = word;
    end
  end

  // ---------------------------------------------------------------------
  // Checks
  // ---------------------------------------------------------------------
  task automatic check_reset_outputs();
    assert (im_en == 1'b0) else begin
      $display("error: im_en_o in reset expected %h got %h", 1'b0, im_en);
      err_cnt++;
    end
    assert (dm_web == WEB_IDLE) else begin
      $display("error: dm_web_o in reset expected %h got %h", WEB_IDLE, dm_web);
      err_cnt++;
    end
  endtask

  // Enable rises one cycle after reset, then one word per cycle
  task automatic check_fetch();
    if (cycle_cnt == 1) begin
      assert (im_en == 1'b0) else begin
        $display("error: im_en_o at cycle 1 expected %h got %h", 1'b0, im_en);
        err_cnt++;
      end
    end else begin
      assert (im_en == 1'b1) else begin
        $display("error: im_en_o at cycle %0d expected %h got %h", cycle_cnt, 1'b1, im_en);
        err_cnt++;
      end
      assert (im_addr == 14'(cycle_cnt - 2)) else begin
        $display("error: im_addr_o expected %h got %h", 14'(cycle_cnt - 2), im_addr);
        err_cnt++;
      end
    end
  endtask

  task automatic check_store_port();
    if (dm_web == WEB_WORD) begin
      assert (store_cnt < exp_addr_q.size()) else begin
        $display("Unexpected extra store to word address %h", dm_addr);
        err_cnt++;
      end
      if (store_cnt < exp_addr_q.size()) begin
        assert (dm_addr == exp_addr_q[store_cnt]) else begin
          $display("error: dm_addr_o store %0d expected %h got %h",
                   store_cnt, exp_addr_q[store_cnt], dm_addr);
          err_cnt++;
        end
        assert (dm_di == exp_data_q[store_cnt]) else begin
          $display("error: dm_di_o store %0d expected %h got %h",
                   store_cnt, exp_data_q[store_cnt], dm_di);
          err_cnt++;
        end
      end
      store_cnt++;
    end else begin
      assert (dm_web == WEB_IDLE) else begin
        $display("error: dm_web_o expected %h got %h", WEB_IDLE, dm_web);
        err_cnt++;
      end
    end
  endtask

  // First edge skipped, reset may not have reached the flops yet
  always @(posedge clk) begin
    if (rst) begin
      if (rst_cycle_cnt > 0) begin
        check_reset_outputs();
      end
      rst_cycle_cnt++;
    end else begin
      cycle_cnt++;
      check_fetch();
      check_store_port();
    end
  end

  // ---------------------------------------------------------------------
  // Main sequence
  // ---------------------------------------------------------------------
  initial begin
    clk           = 1'b0;
    rst           = 1'b1;
    im_data       = NOP_WORD;
    err_cnt       = 0;
    store_cnt     = 0;
    rst_cycle_cnt = 0;
    cycle_cnt     = 0;

    build_tables();
    if (prog_q.size() > IMEM_DEPTH) begin
      $display("Program of %0d words does not fit the instruction memory", prog_q.size());
      err_cnt++;
    end
    load_imem();
    run_limit = prog_q.size() + PIPE_CYCLES + MARGIN_CYCLES;

    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    rst = 1'b0;

    // Counters settle by the falling edge
    while (store_cnt < exp_addr_q.size() && cycle_cnt < run_limit) begin
      @(negedge clk);
    end

    if (store_cnt < exp_addr_q.size()) begin
      $display("Timeout after %0d cycles, only %0d of %0d expected stores were seen",
               cycle_cnt, store_cnt, exp_addr_q.size());
      err_cnt++;
    end else begin
      // Trailing NOPs drain, a stray store still reaches the monitor
      repeat (PIPE_CYCLES) @(negedge clk);
    end

    $display("Errors: %0d, stores checked: %0d of %0d", err_cnt, store_cnt,
             exp_addr_q.size());
    if (err_cnt == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule
